//--- front_ctrl.sv
/* Front control: configuration latch for this block number, row walk over
   the EN beats, DATA_IN alignment with the memory row and FRONT_DONE. */

`timescale 1ns/1ps

module front_ctrl #(
	parameter int BLOCK_ID = 0,
	parameter int NEURONS = 16
) (
	input logic CLK,
	input logic RESET_N,
	input snn_pkg::block_cfg_t CFG,
	input logic START,
	input logic EN,
	input logic [snn_pkg::DATA_W-1:0] DATA_IN,
	output snn_pkg::row_t rd_row,
	output logic [NEURONS-1:0] spikes,
	output logic acc_en,
	output logic clear,
	output logic FRONT_DONE,
	output snn_pkg::grp_code_t grp_code,
	output logic [5:0] outputs
);
	import snn_pkg::*;

	logic [3:0] rows_used_q;
	logic [3:0] beat_cnt;		// Rows read in this phase
	logic armed;				// Set by the first START
	logic beat;
	logic v1;
	logic v1_last;
	logic [DATA_W-1:0] d1;

	////////////////////////////////////////////////////////////////////////////
	// Configuration latch

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			grp_code <= '0;
			rows_used_q <= '0;
			outputs <= '0;
		end else if (CFG.valid && (CFG.id == block_id_t'(BLOCK_ID))) begin
			grp_code <= CFG.grp;
			rows_used_q <= CFG.rows_used;
			outputs <= CFG.outputs;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Row walk

	assign beat = EN & armed & ~START & ~FRONT_DONE & (beat_cnt < rows_used_q);
	assign rd_row = row_t'(beat_cnt);	// Row comes back next cycle
	assign clear = START;
	assign acc_en = v1;

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			armed <= 1'b0;
			beat_cnt <= '0;
			v1 <= 1'b0;
			v1_last <= 1'b0;
			FRONT_DONE <= 1'b0;
		end else begin
			v1 <= beat;
			v1_last <= beat && (beat_cnt + 4'd1 == rows_used_q);
			if (START) begin
				armed <= 1'b1;
				beat_cnt <= '0;
				FRONT_DONE <= 1'b0;
			end else begin
				if (beat)
					beat_cnt <= beat_cnt + 4'd1;
				if (v1_last)
					FRONT_DONE <= 1'b1;	// Same edge as last accumulation
			end
		end
	end

	always_ff @(posedge CLK) begin
		d1 <= DATA_IN;	// Lines up with the memory row
	end

	// Spike bit i comes from DATA_IN bit (i mod group size)
	always_comb begin
		for (int i = 0; i < NEURONS; i++)
			spikes[i] = d1[i & (group_size(grp_code) - 1)];
	end

	a_no_acc_when_done: assert property (@(posedge CLK) disable iff (!RESET_N)
		acc_en |-> !FRONT_DONE);

endmodule

//--- neuron_array.sv
/* Membrane accumulators, one per neuron. START clears them, and each aligned
   beat adds the row weight to every neuron whose spike bit is set. */

`timescale 1ns/1ps

module neuron_array #(
	parameter int NEURONS = 16
) (
	input logic CLK,
	input logic RESET_N,
	input logic clear,
	input logic acc_en,
	input logic [NEURONS-1:0] spikes,
	input snn_pkg::weight_t [NEURONS-1:0] weights,
	output snn_pkg::sum_t [NEURONS-1:0] sums
);
	import snn_pkg::*;

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			sums <= '0;
		end else if (clear) begin
			sums <= '0;	// New front phase
		end else if (acc_en) begin
			for (int i = 0; i < NEURONS; i++) begin
				if (spikes[i])
					sums[i] <= sums[i] + sum_t'(signed'(weights[i]));
			end
		end
	end

endmodule

//--- snn_block_top.sv
/* Top of one SNN accelerator block: weight setup, row memory, front
   accumulation and grouped spike readout. Instances and wiring only. */

`timescale 1ns/1ps

module snn_block_top #(
	parameter int BLOCK_ID = 0,
	parameter int NEURONS = snn_pkg::NUM_NEURONS,
	parameter int ROWS = snn_pkg::NUM_ROWS
) (
	input logic CLK,
	input logic RESET_N,
	input snn_pkg::block_cfg_t CFG,
	input logic W_VALID,
	input snn_pkg::weight_t WEIGHT_IN,
	output logic W_REQUEST,
	output logic W_SET_DONE,
	input logic START,
	input logic EN,
	input logic [snn_pkg::DATA_W-1:0] DATA_IN,
	input logic REQUEST,
	output logic FRONT_DONE,
	output logic OUT_SPIKE,
	output logic OUT_SPIKE_VALID,
	output logic BACK_DONE
);
	import snn_pkg::*;

	logic wr_en;
	row_t wr_row;
	nidx_t wr_neuron;
	weight_t wr_data;
	row_t rd_row;
	weight_t [NEURONS-1:0] rd_weights;	// One memory row
	logic [NEURONS-1:0] spikes;
	logic acc_en;
	logic clear;
	grp_code_t grp_code;
	logic [5:0] outputs;
	sum_t [NEURONS-1:0] sums;

	weight_loader #(.NEURONS(NEURONS), .ROWS(ROWS)) i_loader (
		.CLK(CLK), .RESET_N(RESET_N), .W_VALID(W_VALID), .WEIGHT_IN(WEIGHT_IN),
		.W_REQUEST(W_REQUEST), .W_SET_DONE(W_SET_DONE), .wr_en(wr_en),
		.wr_row(wr_row), .wr_neuron(wr_neuron), .wr_data(wr_data)
	);

	weight_mem #(.NEURONS(NEURONS), .ROWS(ROWS)) i_mem (
		.CLK(CLK), .wr_en(wr_en), .wr_row(wr_row), .wr_neuron(wr_neuron),
		.wr_data(wr_data), .rd_row(rd_row), .rd_weights(rd_weights)
	);

	front_ctrl #(.BLOCK_ID(BLOCK_ID), .NEURONS(NEURONS)) i_front (
		.CLK(CLK), .RESET_N(RESET_N), .CFG(CFG), .START(START), .EN(EN),
		.DATA_IN(DATA_IN), .rd_row(rd_row), .spikes(spikes), .acc_en(acc_en),
		.clear(clear), .FRONT_DONE(FRONT_DONE), .grp_code(grp_code), .outputs(outputs)
	);

	neuron_array #(.NEURONS(NEURONS)) i_neurons (
		.CLK(CLK), .RESET_N(RESET_N), .clear(clear), .acc_en(acc_en),
		.spikes(spikes), .weights(rd_weights), .sums(sums)
	);

	spike_readout #(.NEURONS(NEURONS)) i_readout (
		.CLK(CLK), .RESET_N(RESET_N), .REQUEST(REQUEST), .FRONT_DONE(FRONT_DONE),
		.sums(sums), .grp_code(grp_code), .outputs(outputs), .OUT_SPIKE(OUT_SPIKE),
		.OUT_SPIKE_VALID(OUT_SPIKE_VALID), .BACK_DONE(BACK_DONE)
	);

endmodule

//--- snn_input.txt
// Weight rows 0 to 7: 16 signed bytes each, neuron 0 first
// Records: name id grp rows_used outputs mode d0 d1 d2 d3 d4 d5 d6 d7 mask_hi mask_lo
0a ec 05 fd f8 07 01 ff 1e d8 fe 02 04 fa 09 f7
f6 14 fb 03 08 f9 ff 01 e2 28 02 fe fc 06 f7 09
14 d8 0a fa f0 0e 02 fe 3c b0 fc 04 08 f4 12 ee
ec 28 f6 06 10 f2 fe 02 c4 50 04 fc f8 0c ee 12
0a ec 05 fd f8 07 01 ff 1e d8 fe 02 04 fa 09 f7
f6 14 fb 03 08 f9 ff 01 e2 28 02 fe fc 06 f7 09
14 d8 0a fa f0 0e 02 fe 3c b0 fc 04 08 f4 12 ee
ec 28 f6 06 10 f2 fe 02 c4 50 04 fc f8 0c ee 12
// Group of 1, two rows, later rows would flip every sign
01 03 00 02 10 00 01 00 00 ff 00 ff 00 ff 59 65
// Word for block 5, so block 3 keeps the previous setup
02 05 03 01 02 00 01 00 00 ff 00 ff 00 ff 59 65
// Group of 2, 20 outputs asked, 8 possible
03 03 01 04 14 00 01 02 03 00 02 01 02 01 00 db
// Group of 4, three rows
04 03 02 03 04 00 05 0a 0c 05 00 00 00 00 00 0d
// Group of 8, all rows, 3 outputs asked, 2 possible
05 03 03 08 03 00 ff 0f 10 f0 00 00 00 00 00 02
// Same as the group of 4 case, new front phase during readout
06 03 02 03 04 01 05 0a 0c 05 00 00 00 00 00 0d

//--- snn_pkg.sv
/* Widths, types, configuration word and group-size rule shared by the SNN block.
   Modules import it inside their bodies and use scoped names in their headers. */

package snn_pkg;

	localparam int NUM_NEURONS = 16;	// Default neuron count
	localparam int NUM_ROWS = 8;		// Default memory depth
	localparam int DATA_W = 8;			// DATA_IN width

	typedef logic signed [7:0] weight_t;
	typedef logic signed [11:0] sum_t;	// 8 full-scale rows fit without saturation
	typedef logic [2:0] row_t;
	typedef logic [3:0] nidx_t;
	typedef logic [1:0] grp_code_t;		// Group size is 2**code
	typedef logic [3:0] block_id_t;

	// Broadcast configuration word of 17 bits
	typedef struct packed {
		logic valid;
		block_id_t id;
		grp_code_t grp;
		logic [3:0] rows_used;
		logic [5:0] outputs;
	} block_cfg_t;

	// Neurons per output group
	function automatic int unsigned group_size(grp_code_t code);
		return 1 << code;
	endfunction

endpackage

//--- spike_readout.sv
/* Back end: captures the membrane sums on REQUEST and sends one spike per
   neuron group, one per cycle, so a new front phase can run meanwhile. */

`timescale 1ns/1ps

module spike_readout #(
	parameter int NEURONS = 16
) (
	input logic CLK,
	input logic RESET_N,
	input logic REQUEST,
	input logic FRONT_DONE,
	input snn_pkg::sum_t [NEURONS-1:0] sums,
	input snn_pkg::grp_code_t grp_code,
	input logic [5:0] outputs,
	output logic OUT_SPIKE,
	output logic OUT_SPIKE_VALID,
	output logic BACK_DONE
);
	import snn_pkg::*;

	localparam int MAX_GROUP = 1 << (2 ** $bits(grp_code_t) - 1);	// 8 neurons
	localparam int GSUM_W = $bits(sum_t) + $clog2(MAX_GROUP);

	typedef enum logic [1:0] {ST_IDLE, ST_EMIT, ST_DONE} rd_state_t;

	rd_state_t state;
	sum_t [NEURONS-1:0] cap_sums;
	grp_code_t cap_grp;
	logic [5:0] out_cnt;
	logic [5:0] out_last;
	logic [5:0] out_lim;
	logic signed [GSUM_W-1:0] grp_sum;
	logic accept;

	assign accept = REQUEST & FRONT_DONE;

	// No more outputs than whole groups
	always_comb begin
		int unsigned max_out;
		max_out = NEURONS >> grp_code;
		out_lim = (outputs > max_out) ? 6'(max_out) : outputs;
	end

	////////////////////////////////////////////////////////////////////////////
	// Readout FSM

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			state <= ST_IDLE;
			out_cnt <= '0;
			out_last <= '0;
			cap_grp <= '0;
		end else if (accept) begin
			cap_grp <= grp_code;
			out_cnt <= '0;
			out_last <= out_lim - 6'd1;
			state <= (out_lim == '0) ? ST_DONE : ST_EMIT;
		end else if (state == ST_EMIT) begin
			out_cnt <= out_cnt + 6'd1;
			if (out_cnt == out_last)
				state <= ST_DONE;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept)
			cap_sums <= sums;	// Held while the next front phase runs
	end

	// Group reduction for the current output
	always_comb begin
		int unsigned gs;
		int unsigned base;
		gs = group_size(cap_grp);
		base = out_cnt << cap_grp;
		grp_sum = '0;
		for (int unsigned k = 0; k < MAX_GROUP; k++) begin
			if ((k < gs) && (base + k < NEURONS))
				grp_sum += GSUM_W'(signed'(cap_sums[base + k]));
		end
	end

	assign OUT_SPIKE_VALID = (state == ST_EMIT);
	assign OUT_SPIKE = OUT_SPIKE_VALID & ~grp_sum[GSUM_W-1];	// Sign clear
	assign BACK_DONE = (state == ST_DONE);

	// A readout only starts on the cycle after an accepted REQUEST
	a_emit_after_request: assert property (@(posedge CLK) disable iff (!RESET_N)
		$rose(OUT_SPIKE_VALID) |-> $past(accept));

endmodule

//--- tb.f
snn_pkg.sv
weight_loader.sv
weight_mem.sv
front_ctrl.sv
neuron_array.sv
spike_readout.sv
snn_block_top.sv
tb_clk_gen.sv
tb_snn_block.sv

//--- tb_clk_gen.sv
/* Testbench clock and reset source. The clock runs free and reset is held
   low for the first cycles, then released just after a rising edge. */

`timescale 1ns/1ps

module tb_clk_gen #(
	parameter real PERIOD = 20.0,
	parameter int RESET_CYCLES = 2
) (
	output logic CLK,
	output logic RESET_N
);
	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2.0) CLK = ~CLK;
	end

	initial begin
		RESET_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2 RESET_N = 1'b1;	// Off the clock edge
	end

endmodule

//--- tb_snn_block.sv
/* Testbench for one SNN block. Loads the weights and test records from the
   input file, runs setup, front and back phases and checks the group spikes. */

`timescale 1ns/1ps

module tb_snn_block;
	import snn_pkg::*;

	localparam int BLOCK_ID = 3;
	localparam int N_NEURONS = 16;
	localparam int N_ROWS = 8;
	localparam int N_WEIGHTS = N_NEURONS * N_ROWS;
	localparam int N_TESTS = 6;
	localparam int REC_LEN = 16;		// Bytes per test record
	localparam int IN_WORDS = N_WEIGHTS + N_TESTS * REC_LEN;
	localparam int DRIVE_DLY = 2;
	localparam int SEED = 10;
	localparam int LIMIT_CYCLES = N_WEIGHTS + N_TESTS * 40;

	logic CLK;
	logic RESET_N;
	block_cfg_t cfg;
	logic w_valid;
	weight_t weight_in;
	logic w_request;
	logic w_set_done;
	logic start;
	logic en;
	logic [DATA_W-1:0] data_in;
	logic request;
	logic front_done;
	logic out_spike;
	logic out_spike_valid;
	logic back_done;

	logic [7:0] in_mem [0:IN_WORDS-1];
	grp_code_t cur_grp;			// Configuration the block should hold
	logic [3:0] cur_rows;
	logic [5:0] cur_outputs;
	int errors;
	int checks;

	tb_clk_gen #(.PERIOD(20.0), .RESET_CYCLES(2)) i_clk_gen (.CLK(CLK), .RESET_N(RESET_N));

	snn_block_top #(.BLOCK_ID(BLOCK_ID), .NEURONS(N_NEURONS), .ROWS(N_ROWS)) i_dut (
		.CLK(CLK), .RESET_N(RESET_N), .CFG(cfg), .W_VALID(w_valid), .WEIGHT_IN(weight_in),
		.W_REQUEST(w_request), .W_SET_DONE(w_set_done), .START(start), .EN(en),
		.DATA_IN(data_in), .REQUEST(request), .FRONT_DONE(front_done),
		.OUT_SPIKE(out_spike), .OUT_SPIKE_VALID(out_spike_valid), .BACK_DONE(back_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic step();
		@(posedge CLK);
		#DRIVE_DLY;
	endtask

	task automatic check_value(input string test, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Error: test %s, %s: expected %0h, actual %0h", test, what, exp, act);
		end
	endtask

	function automatic string test_name(input logic [7:0] code);
		case (code)
			8'h01: return "grp1_rows2";
			8'h02: return "other_block_id";
			8'h03: return "grp2_clamp";
			8'h04: return "grp4_rows3";
			8'h05: return "grp8_clamp";
			8'h06: return "overlap_readout";
			default: return "unknown";
		endcase
	endfunction

	task automatic load_weights();
		string name;
		int err_before;
		name = "weight_setup";
		err_before = errors;
		for (int i = 0; i < N_WEIGHTS; i++) begin
			check_value(name, "W_REQUEST during setup", 1, w_request);
			check_value(name, "W_SET_DONE before last strobe", 0, w_set_done);
			w_valid = 1'b1;
			weight_in = in_mem[i];
			step();
		end
		// Late strobes would land in row 0 if they were taken
		for (int i = 0; i < 4; i++) begin
			check_value(name, "W_SET_DONE after setup", 1, w_set_done);
			check_value(name, "W_REQUEST after setup", 0, w_request);
			weight_in = 8'h7f;
			step();
		end
		w_valid = 1'b0;
		check_value(name, "W_SET_DONE held", 1, w_set_done);
		$display("Test %s finished: %0d errors", name, errors - err_before);
	endtask

	// Eight EN beats from a record with random idle gaps unless overlapping
	task automatic drive_beats(input string name, input int base, input int rows,
			input bit overlap);
		int gap;
		for (int r = 0; r < N_ROWS; r++) begin
			gap = overlap ? 0 : int'($urandom % 2);
			en = 1'b0;
			repeat (gap)
				step();
			en = 1'b1;
			data_in = overlap ? ~in_mem[base + 6 + r] : in_mem[base + 6 + r];
			request = (r == 0) && !overlap;	// FRONT_DONE is low here
			step();
			request = 1'b0;
			if (!overlap) begin
				check_value(name, "OUT_SPIKE_VALID in front phase", 0, out_spike_valid);
				check_value(name, "FRONT_DONE after beat", (r >= rows) ? 1 : 0, front_done);
			end
		end
		en = 1'b0;
	endtask

	task automatic collect_spikes(input string name, output int cnt, output logic [15:0] mask);
		cnt = 0;
		mask = '0;
		while (back_done !== 1'b1) begin
			check_value(name, "OUT_SPIKE_VALID before BACK_DONE", 1, out_spike_valid);
			if (out_spike_valid === 1'b1) begin
				if (cnt < 16)
					mask[cnt] = out_spike;
				cnt++;
			end
			step();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One test record

	task automatic run_test(input int t);
		int base;
		int err_before;
		int exp_cnt;
		int cnt;
		string name;
		logic [7:0] id;
		logic [15:0] exp_mask;
		logic [15:0] mask;
		base = N_WEIGHTS + t * REC_LEN;
		name = test_name(in_mem[base]);
		id = in_mem[base + 1];
		err_before = errors;
		cfg = '{valid: 1'b1, id: id[3:0], grp: in_mem[base + 2][1:0],
			rows_used: in_mem[base + 3][3:0], outputs: in_mem[base + 4][5:0]};
		step();
		cfg = '0;
		if (id == BLOCK_ID) begin	// Other ids leave the old setup
			cur_grp = in_mem[base + 2][1:0];
			cur_rows = in_mem[base + 3][3:0];
			cur_outputs = in_mem[base + 4][5:0];
		end
		exp_cnt = N_NEURONS / (2 ** cur_grp);
		if (cur_outputs < exp_cnt)
			exp_cnt = cur_outputs;
		exp_mask = {in_mem[base + 14], in_mem[base + 15]};
		start = 1'b1;
		step();
		start = 1'b0;
		drive_beats(name, base, int'(cur_rows), 1'b0);
		while (front_done !== 1'b1)
			step();
		request = 1'b1;
		step();
		request = 1'b0;
		if (in_mem[base + 5] == 8'h01) begin
			fork
				collect_spikes(name, cnt, mask);
				begin
					start = 1'b1;	// Next front phase during readout
					step();
					start = 1'b0;
					drive_beats(name, base, int'(cur_rows), 1'b1);
				end
			join
		end else begin
			collect_spikes(name, cnt, mask);
		end
		check_value(name, "output count", exp_cnt, cnt);
		check_value(name, "spike mask", exp_mask, mask);
		check_value(name, "OUT_SPIKE_VALID with BACK_DONE", 0, out_spike_valid);
		$display("Test %s finished: %0d outputs, mask %04h, %0d errors",
			name, cnt, mask, errors - err_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		cfg = '0;
		w_valid = 1'b0;
		weight_in = '0;
		start = 1'b0;
		en = 1'b0;
		data_in = '0;
		request = 1'b0;
		cur_grp = '0;
		cur_rows = '0;
		cur_outputs = '0;
		errors = 0;
		checks = 0;
		void'($urandom(SEED));
		$readmemh("snn_input.txt", in_mem);
		wait (RESET_N === 1'b1);
		step();
		load_weights();
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		$display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS + 1, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge CLK);
		$display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- weight_loader.sv
/* Turns the host weight strobes into memory writes, neuron index first,
   and holds the setup request and done levels. */

`timescale 1ns/1ps

module weight_loader #(
	parameter int NEURONS = 16,
	parameter int ROWS = 8
) (
	input logic CLK,
	input logic RESET_N,
	input logic W_VALID,
	input snn_pkg::weight_t WEIGHT_IN,
	output logic W_REQUEST,
	output logic W_SET_DONE,
	output logic wr_en,
	output snn_pkg::row_t wr_row,
	output snn_pkg::nidx_t wr_neuron,
	output snn_pkg::weight_t wr_data
);
	import snn_pkg::*;

	logic last_wr;

	assign wr_en = W_VALID & ~W_SET_DONE;	// Late strobes dropped
	assign wr_data = WEIGHT_IN;
	assign last_wr = wr_en && (wr_neuron == nidx_t'(NEURONS - 1))
		&& (wr_row == row_t'(ROWS - 1));

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			wr_neuron <= '0;
			wr_row <= '0;
			W_SET_DONE <= 1'b0;
			W_REQUEST <= 1'b0;
		end else begin
			W_REQUEST <= ~(W_SET_DONE | last_wr);	// Falls with the done edge
			if (last_wr)
				W_SET_DONE <= 1'b1;
			if (wr_en) begin
				if (wr_neuron == nidx_t'(NEURONS - 1)) begin
					wr_neuron <= '0;
					wr_row <= wr_row + 1'b1;
				end else begin
					wr_neuron <= wr_neuron + 1'b1;
				end
			end
		end
	end

	// Write address stays put once setup is done
	a_no_write_after_done: assert property (@(posedge CLK) disable iff (!RESET_N)
		W_SET_DONE |=> $stable({wr_row, wr_neuron}));

endmodule

//--- weight_mem.sv
/* Weight row memory. One weight is written per strobe and a whole row
   is read back one cycle after its address. */

`timescale 1ns/1ps

module weight_mem #(
	parameter int NEURONS = 16,
	parameter int ROWS = 8
) (
	input logic CLK,
	input logic wr_en,
	input snn_pkg::row_t wr_row,
	input snn_pkg::nidx_t wr_neuron,
	input snn_pkg::weight_t wr_data,
	input snn_pkg::row_t rd_row,
	output snn_pkg::weight_t [NEURONS-1:0] rd_weights
);
	import snn_pkg::*;

	weight_t [NEURONS-1:0] mem [ROWS];

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_row][wr_neuron] <= wr_data;
		rd_weights <= mem[rd_row];	// Synchronous read
	end

endmodule
